/* tb.f */
+incdir+src
src/usb_desc_pkg.sv
src/desc_region_decode.sv
src/desc_id_override.sv
src/desc_std_bytes.sv
src/desc_string_bytes.sv
src/desc_byte_select.sv
src/usb_desc_top.sv
bench/tb_usb_desc.sv

/* bench/tb_usb_desc.sv */
`include "usb_desc_params.svh"

module tb_usb_desc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DRAIN_LIMIT = 1000;  // cycles allowed per read batch

  logic        CLK;
  logic        RESET;
  logic [15:0] i_raddr;
  logic [15:0] i_vendor_id;
  logic [15:0] i_product_id;
  logic [7:0]  o_rdat;

  logic [7:0]  ref_rom [0:255];  // expected image for the current ids
  logic [15:0] addr_q[$];        // reads not yet issued
  logic [16:0] pipe_q[$];        // one slot per cycle, bit 16 = real read
  int          checks;
  int          errors;
  int          timeouts;
  int          seed;

  usb_desc_top dut0 (
    .CLK          (CLK),
    .RESET        (RESET),
    .i_raddr      (i_raddr),
    .i_vendor_id  (i_vendor_id),
    .i_product_id (i_product_id),
    .o_rdat       (o_rdat)
  );

  always #2 CLK = ~CLK;  // 4 ns period

  // unprogrammed straps fall back to the built-in id
  function automatic logic [15:0] eff_id(input logic [15:0] id, input logic [15:0] dflt);
    return (id == 16'h0000 || id == 16'hFFFF) ? dflt : id;
  endfunction

  // data right aligned, first byte in the highest used lane
  task automatic put_bytes(input int base, input int len, input logic [255:0] data);
    int i;
    for (i = 0; i < len; i++)
      ref_rom[base + i] = data[(len - 1 - i) * 8 +: 8];
  endtask

  task automatic put_string(input int base, input logic [255:0] str, input int len);
    int i;
    ref_rom[base]     = 8'(2 + 2 * len);  // bLength
    ref_rom[base + 1] = 8'h03;
    for (i = 0; i < len; i++) begin
      ref_rom[base + 2 + 2 * i] = str[(len - 1 - i) * 8 +: 8];  // ascii char
      ref_rom[base + 3 + 2 * i] = 8'h00;                        // utf-16le high byte
    end
  endtask

  task automatic build_ref_rom(input logic [15:0] vid, input logic [15:0] pid);
    logic [15:0] ver;
    logic [15:0] mp;     // bulk packet size
    logic [7:0]  attr;
    logic [7:0]  ctype;
    int          base;
    int          i;
    ver  = `USB_VERSION_BCD;
    attr = (`USB_SELF_POWERED != 0) ? 8'hC0 : 8'h80;
    for (i = 0; i < 256; i++)
      ref_rom[i] = 8'h00;  // pads and tail read zero
    put_bytes(`USB_DESC_DEV_ADDR, 18, {8'h12, 8'h01, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00,
      `USB_EP0_MAXPKT, vid[7:0], vid[15:8], pid[7:0], pid[15:8], ver[7:0], ver[15:8],
      8'h01, 8'h02, 8'h03, 8'h01});
    put_bytes(`USB_DESC_QUAL_ADDR, 10, {8'h0A, 8'h06, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00,
      `USB_EP0_MAXPKT, 8'h01, 8'h00});
    for (i = 0; i < 3; i++) begin  // fs, hs, other speed
      base  = (i == 0) ? `USB_DESC_FSCFG_ADDR : (i == 1) ? `USB_DESC_HSCFG_ADDR
                                                          : `USB_DESC_OSCFG_ADDR;
      mp    = (i == 1) ? `USB_HS_MAXPKT : `USB_FS_MAXPKT;
      ctype = (i == 2) ? 8'h07 : 8'h02;
      put_bytes(base, 32, {8'h09, ctype, 8'd32, 8'h00, 8'h01, 8'h01, 8'h00, attr,
        `USB_MAX_POWER, 8'h09, 8'h04, 8'h00, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00, 8'h00,
        8'h07, 8'h05, 8'h81, 8'h02, mp[7:0], mp[15:8], 8'h00,
        8'h07, 8'h05, 8'h01, 8'h02, mp[7:0], mp[15:8], 8'h00});
    end
    put_bytes(`USB_DESC_STRLANG_ADDR, 4, {8'h04, 8'h03, 8'h09, 8'h04});
    put_string(`USB_DESC_STRVENDOR_ADDR, `USB_VENDOR_STR, `USB_VENDOR_STR_LEN);
    put_string(`USB_DESC_STRPRODUCT_ADDR, `USB_PRODUCT_STR, `USB_PRODUCT_STR_LEN);
    put_string(`USB_DESC_STRSERIAL_ADDR, `USB_SERIAL_STR, `USB_SERIAL_STR_LEN);
  endtask

  task automatic queue_range(input int lo, input int hi);
    int a;
    for (a = lo; a < hi; a++)
      addr_q.push_back(16'(a));
  endtask

  // one address per edge, result checked two edges later
  task automatic issue_reads();
    int          guard;
    int          live;  // real reads in flight
    logic [15:0] a;
    logic [16:0] slot;
    logic [7:0]  exp;
    guard = 0;
    live  = 0;
    while ((addr_q.size() > 0 || live > 0) && guard < DRAIN_LIMIT) begin
      @(posedge CLK);
      if (addr_q.size() > 0) begin
        a = addr_q.pop_front();
        i_raddr <= a;
        pipe_q.push_back({1'b1, a});
        live++;
      end else begin
        i_raddr <= 16'hFFFF;  // idle, decodes to nothing
        pipe_q.push_back(17'h0FFFF);
      end
      @(negedge CLK);
      if (pipe_q.size() == 3) begin  // oldest slot driven two edges back
        slot = pipe_q.pop_front();
        if (slot[16]) begin
          live--;
          exp = (slot[15:0] < 16'd256) ? ref_rom[slot[7:0]] : 8'h00;
          checks++;
          assert (o_rdat === exp) else begin
            $display("CHECK FAILED t=%0t o_rdat addr=%04h got=%02h exp=%02h",
                     $time, slot[15:0], o_rdat, exp);
            errors++;
          end
        end
      end
      guard++;
    end
    if (addr_q.size() > 0 || live > 0) begin
      $display("timeout: read batch still busy after %0d cycles", DRAIN_LIMIT);
      timeouts++;
      addr_q.delete();
    end
    pipe_q.delete();
  endtask

  task automatic set_ids(input logic [15:0] vid, input logic [15:0] pid);
    @(posedge CLK);
    i_vendor_id  <= vid;
    i_product_id <= pid;
    build_ref_rom(eff_id(vid, `USB_VENDOR_ID), eff_id(pid, `USB_PRODUCT_ID));
  endtask

  task automatic test_device_qual();
    set_ids(16'h0000, 16'h0000);  // both straps unprogrammed
    queue_range(0, 32);
    issue_reads();
  endtask

  task automatic test_configs();
    queue_range(`USB_DESC_FSCFG_ADDR, `USB_DESC_STRLANG_ADDR);  // fs, hs, os
    issue_reads();
  endtask

  task automatic test_strings_tail();
    queue_range(`USB_DESC_STRLANG_ADDR, 256);  // strings, then zeros from END
    addr_q.push_back(16'h0100);
    addr_q.push_back(16'h1234);
    addr_q.push_back(16'hFFFF);
    issue_reads();
  endtask

  task automatic test_id_override();
    set_ids(16'h1234, 16'h5678);
    queue_range(0, 18);
    issue_reads();
    set_ids(16'hFFFF, 16'h0000);  // both back to defaults
    queue_range(8, 12);
    issue_reads();
    set_ids(16'hABCD, 16'hFFFF);
    queue_range(8, 12);
    issue_reads();
    set_ids(16'h0000, 16'hBEEF);
    queue_range(8, 12);
    issue_reads();
  endtask

  task automatic test_random();
    int n;
    seed = 32'hace4;
    for (n = 0; n < 200; n++)
      addr_q.push_back(16'($random(seed) & 255));
    issue_reads();  // back to back, no gaps
  endtask

  initial begin
    CLK          = 1'b0;
    RESET        = 1'b1;
    i_raddr      = 16'h0000;
    i_vendor_id  = 16'h0000;
    i_product_id = 16'h0000;
    checks       = 0;
    errors       = 0;
    timeouts     = 0;
    repeat (9) @(posedge CLK);
    @(negedge CLK);
    checks++;
    assert (o_rdat === 8'h00) else begin
      $display("CHECK FAILED t=%0t o_rdat got=%02h exp=00", $time, o_rdat);
      errors++;
    end
    @(posedge CLK);
    RESET <= 1'b0;  // 10 cycles in reset
    test_device_qual();
    test_configs();
    test_strings_tail();
    test_id_override();
    test_random();
    $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* src/usb_desc_top.sv */
module usb_desc_top (
  input  logic                      CLK,
  input  logic                      RESET,
  input  usb_desc_pkg::desc_addr_t  i_raddr,       // new address every cycle
  input  logic [15:0]               i_vendor_id,   // runtime vid, 0000/ffff = default
  input  logic [15:0]               i_product_id,  // runtime pid, same rule
  output usb_desc_pkg::desc_byte_t  o_rdat         // byte for i_raddr two edges back
);

  usb_desc_pkg::desc_region_e  region;      // stage 1 region
  usb_desc_pkg::desc_offset_t  offset;      // stage 1 offset
  logic [15:0]                 vendor_id;   // active idVendor
  logic [15:0]                 product_id;  // active idProduct
  usb_desc_pkg::desc_byte_t    std_byte;    // device/qual/config byte
  usb_desc_pkg::desc_byte_t    str_byte;    // string byte

  desc_region_decode u_decode (  // stage 1
    .CLK      (CLK),
    .RESET    (RESET),
    .i_raddr  (i_raddr),
    .o_region (region),
    .o_offset (offset)
  );

  desc_id_override u_ids (
    .CLK          (CLK),
    .RESET        (RESET),
    .i_vendor_id  (i_vendor_id),
    .i_product_id (i_product_id),
    .o_vendor_id  (vendor_id),
    .o_product_id (product_id)
  );

  desc_std_bytes u_std (
    .i_region     (region),
    .i_offset     (offset),
    .i_vendor_id  (vendor_id),
    .i_product_id (product_id),
    .o_byte       (std_byte)
  );

  desc_string_bytes u_str (
    .i_region (region),
    .i_offset (offset),
    .o_byte   (str_byte)
  );

  desc_byte_select u_select (  // stage 2
    .CLK        (CLK),
    .RESET      (RESET),
    .i_region   (region),
    .i_std_byte (std_byte),
    .i_str_byte (str_byte),
    .o_rdat     (o_rdat)
  );

endmodule

/* src/desc_byte_select.sv */
module desc_byte_select (
  input  logic                        CLK,
  input  logic                        RESET,
  input  usb_desc_pkg::desc_region_e  i_region,    // stage 1 region
  input  usb_desc_pkg::desc_byte_t    i_std_byte,  // device/qual/config path
  input  usb_desc_pkg::desc_byte_t    i_str_byte,  // string path
  output usb_desc_pkg::desc_byte_t    o_rdat       // stage 2 output
);

  usb_desc_pkg::desc_byte_t next_byte;  // byte to register

  always_comb begin
    case (i_region)
      usb_desc_pkg::REG_NONE:       next_byte = 8'h00;  // pads and past the end
      usb_desc_pkg::REG_STRLANG,
      usb_desc_pkg::REG_STRVENDOR,
      usb_desc_pkg::REG_STRPRODUCT,
      usb_desc_pkg::REG_STRSERIAL:  next_byte = i_str_byte;
      default:                      next_byte = i_std_byte;
    endcase
  end

  always_ff @(posedge CLK or posedge RESET) begin
    if (RESET) begin
      o_rdat <= '0;
    end else begin
      o_rdat <= next_byte;
    end
  end

endmodule

/* src/desc_string_bytes.sv */
`include "usb_desc_params.svh"

module desc_string_bytes (
  input  usb_desc_pkg::desc_region_e  i_region,
  input  usb_desc_pkg::desc_offset_t  i_offset,
  output usb_desc_pkg::desc_byte_t    o_byte
);

  // literals right aligned, first char in the top used byte
  localparam logic [255:0] VENDOR_STR  = `USB_VENDOR_STR;
  localparam logic [255:0] PRODUCT_STR = `USB_PRODUCT_STR;
  localparam logic [255:0] SERIAL_STR  = `USB_SERIAL_STR;

  usb_desc_pkg::desc_byte_t lang_byte;  // string 0 byte

  // utf-16le string descriptor byte at off
  function automatic usb_desc_pkg::desc_byte_t utf16_byte(
    input logic [255:0]               str,
    input int                         len,
    input usb_desc_pkg::desc_offset_t off
  );
    int idx;
    idx = int'(off >> 1) - 1;                    // char index for even offsets
    if (off == 8'd0)
      utf16_byte = 8'(2 + 2 * len);              // bLength
    else if (off == 8'd1)
      utf16_byte = 8'h03;                        // string type
    else if (off[0] || idx >= len)
      utf16_byte = 8'h00;                        // high half of each char
    else
      utf16_byte = str[(len - 1 - idx) * 8 +: 8];
  endfunction

  always_comb begin
    case (i_offset)
      8'd0:    lang_byte = 8'h04;
      8'd1:    lang_byte = 8'h03;
      8'd2:    lang_byte = 8'h09;  // 0409, english us
      8'd3:    lang_byte = 8'h04;
      default: lang_byte = 8'h00;
    endcase
  end

  always_comb begin
    case (i_region)
      usb_desc_pkg::REG_STRLANG:    o_byte = lang_byte;
      usb_desc_pkg::REG_STRVENDOR:
        o_byte = utf16_byte(VENDOR_STR, `USB_VENDOR_STR_LEN, i_offset);
      usb_desc_pkg::REG_STRPRODUCT:
        o_byte = utf16_byte(PRODUCT_STR, `USB_PRODUCT_STR_LEN, i_offset);
      usb_desc_pkg::REG_STRSERIAL:
        o_byte = utf16_byte(SERIAL_STR, `USB_SERIAL_STR_LEN, i_offset);
      default:                      o_byte = 8'h00;
    endcase
  end

endmodule

/* src/desc_std_bytes.sv */
`include "usb_desc_params.svh"

module desc_std_bytes (
  input  usb_desc_pkg::desc_region_e  i_region,
  input  usb_desc_pkg::desc_offset_t  i_offset,
  input  logic [15:0]                 i_vendor_id,   // already filtered
  input  logic [15:0]                 i_product_id,
  output usb_desc_pkg::desc_byte_t    o_byte
);

  localparam logic [7:0] CFG_ATTR = (`USB_SELF_POWERED != 0) ? 8'hC0 : 8'h80;  // bmAttributes
  localparam logic [15:0] CFG_TOTAL_LEN = 16'(`USB_DESC_FSCFG_LEN);  // wTotalLength of every speed
  localparam logic [15:0] VERSION_BCD   = `USB_VERSION_BCD;          // bcdDevice

  usb_desc_pkg::desc_byte_t  dev_byte;   // device descriptor byte
  usb_desc_pkg::desc_byte_t  qual_byte;  // qualifier byte
  usb_desc_pkg::desc_byte_t  cfg_byte;   // config table byte
  logic [7:0]                cfg_type;   // 02 config or 07 other speed
  logic [15:0]               ep_maxpkt;  // bulk wMaxPacketSize

  always_comb begin
    case (i_offset)
      8'd0:    dev_byte = 8'h12;                      // bLength
      8'd1:    dev_byte = 8'h01;                      // device type
      8'd2:    dev_byte = 8'h00;                      // bcdUSB 2.00
      8'd3:    dev_byte = 8'h02;
      8'd4:    dev_byte = 8'hFF;                      // vendor class
      8'd7:    dev_byte = `USB_EP0_MAXPKT;
      8'd8:    dev_byte = i_vendor_id[7:0];           // idVendor low byte first
      8'd9:    dev_byte = i_vendor_id[15:8];
      8'd10:   dev_byte = i_product_id[7:0];          // idProduct
      8'd11:   dev_byte = i_product_id[15:8];
      8'd12:   dev_byte = VERSION_BCD[7:0];           // bcdDevice lo
      8'd13:   dev_byte = VERSION_BCD[15:8];          // bcdDevice hi
      8'd14:   dev_byte = 8'h01;                      // iManufacturer
      8'd15:   dev_byte = 8'h02;                      // iProduct
      8'd16:   dev_byte = 8'h03;                      // iSerialNumber
      8'd17:   dev_byte = 8'h01;                      // one configuration
      default: dev_byte = 8'h00;                      // subclass and protocol
    endcase
  end

  always_comb begin
    case (i_offset)
      8'd0:    qual_byte = 8'h0A;  // bLength
      8'd1:    qual_byte = 8'h06;  // qualifier type
      8'd3:    qual_byte = 8'h02;  // bcdUSB hi
      8'd4:    qual_byte = 8'hFF;  // vendor class
      8'd7:    qual_byte = `USB_EP0_MAXPKT;
      8'd8:    qual_byte = 8'h01;  // other-speed configs
      default: qual_byte = 8'h00;  // includes bReserved
    endcase
  end

  // per-speed fields of the shared table
  always_comb begin
    cfg_type  = 8'h02;
    ep_maxpkt = `USB_FS_MAXPKT;
    if (i_region == usb_desc_pkg::REG_HSCFG) begin
      ep_maxpkt = `USB_HS_MAXPKT;  // 512 at high speed
    end else if (i_region == usb_desc_pkg::REG_OSCFG) begin
      cfg_type  = 8'h07;          // other speed config
    end
  end

  always_comb begin
    case (i_offset)
      8'd0:    cfg_byte = 8'h09;            // config header
      8'd1:    cfg_byte = cfg_type;
      8'd2:    cfg_byte = CFG_TOTAL_LEN[7:0];
      8'd3:    cfg_byte = CFG_TOTAL_LEN[15:8];
      8'd4:    cfg_byte = 8'h01;            // one interface
      8'd5:    cfg_byte = 8'h01;            // bConfigurationValue
      8'd7:    cfg_byte = CFG_ATTR;
      8'd8:    cfg_byte = `USB_MAX_POWER;
      8'd9:    cfg_byte = 8'h09;            // interface descriptor
      8'd10:   cfg_byte = 8'h04;
      8'd13:   cfg_byte = 8'h02;            // two endpoints
      8'd14:   cfg_byte = 8'hFF;            // vendor class
      8'd18:   cfg_byte = 8'h07;            // ep1 in carries video to host
      8'd19:   cfg_byte = 8'h05;
      8'd20:   cfg_byte = 8'h81;
      8'd21:   cfg_byte = 8'h02;            // bulk
      8'd22:   cfg_byte = ep_maxpkt[7:0];
      8'd23:   cfg_byte = ep_maxpkt[15:8];
      8'd25:   cfg_byte = 8'h07;            // ep1 out from host
      8'd26:   cfg_byte = 8'h05;
      8'd27:   cfg_byte = 8'h01;
      8'd28:   cfg_byte = 8'h02;            // bulk
      8'd29:   cfg_byte = ep_maxpkt[7:0];
      8'd30:   cfg_byte = ep_maxpkt[15:8];
      default: cfg_byte = 8'h00;            // string indexes and bInterval
    endcase
  end

  always_comb begin
    case (i_region)
      usb_desc_pkg::REG_DEV:   o_byte = dev_byte;
      usb_desc_pkg::REG_QUAL:  o_byte = qual_byte;
      usb_desc_pkg::REG_FSCFG,
      usb_desc_pkg::REG_HSCFG,
      usb_desc_pkg::REG_OSCFG: o_byte = cfg_byte;
      default:                 o_byte = 8'h00;  // strings handled elsewhere
    endcase
  end

endmodule

/* src/desc_id_override.sv */
`include "usb_desc_params.svh"

module desc_id_override (
  input  logic        CLK,
  input  logic        RESET,
  input  logic [15:0] i_vendor_id,
  input  logic [15:0] i_product_id,
  output logic [15:0] o_vendor_id,   // active idVendor
  output logic [15:0] o_product_id   // active idProduct
);

  logic vendor_ok;   // input vid usable
  logic product_ok;  // input pid usable

  // all zeros and all ones mean unprogrammed straps
  function automatic logic id_valid(input logic [15:0] id);
    id_valid = (id != 16'h0000) && (id != 16'hFFFF);
  endfunction

  assign vendor_ok  = id_valid(i_vendor_id);
  assign product_ok = id_valid(i_product_id);

  always_ff @(posedge CLK or posedge RESET) begin
    if (RESET) begin
      o_vendor_id  <= `USB_VENDOR_ID;   // built-in ids until first edge
      o_product_id <= `USB_PRODUCT_ID;
    end else begin
      o_vendor_id  <= vendor_ok ? i_vendor_id : `USB_VENDOR_ID;
      o_product_id <= product_ok ? i_product_id : `USB_PRODUCT_ID;
    end
  end

endmodule

/* src/desc_region_decode.sv */
`include "usb_desc_params.svh"

module desc_region_decode (
  input  logic                        CLK,
  input  logic                        RESET,
  input  usb_desc_pkg::desc_addr_t    i_raddr,
  output usb_desc_pkg::desc_region_e  o_region,  // registered region
  output usb_desc_pkg::desc_offset_t  o_offset   // registered offset from region start
);

  usb_desc_pkg::desc_region_e  region_d;  // next region
  logic [15:0]                 start;     // start of matched region
  logic [15:0]                 diff;      // address minus start

  // true when addr sits in [base, base+len)
  function automatic logic in_range(input logic [15:0] addr, input int base, input int len);
    in_range = (int'(addr) >= base) && (int'(addr) < base + len);
  endfunction

  always_comb begin
    region_d = usb_desc_pkg::REG_NONE;  // pads fall through to here
    start    = 16'd0;
    if (int'(i_raddr) >= `USB_DESC_END_ADDR) begin
      region_d = usb_desc_pkg::REG_NONE;  // past the last string
    end else if (in_range(i_raddr, `USB_DESC_DEV_ADDR, `USB_DESC_DEV_LEN)) begin
      region_d = usb_desc_pkg::REG_DEV;
      start    = 16'(`USB_DESC_DEV_ADDR);
    end else if (in_range(i_raddr, `USB_DESC_QUAL_ADDR, `USB_DESC_QUAL_LEN)) begin
      region_d = usb_desc_pkg::REG_QUAL;
      start    = 16'(`USB_DESC_QUAL_ADDR);
    end else if (in_range(i_raddr, `USB_DESC_FSCFG_ADDR, `USB_DESC_FSCFG_LEN)) begin
      region_d = usb_desc_pkg::REG_FSCFG;
      start    = 16'(`USB_DESC_FSCFG_ADDR);
    end else if (in_range(i_raddr, `USB_DESC_HSCFG_ADDR, `USB_DESC_HSCFG_LEN)) begin
      region_d = usb_desc_pkg::REG_HSCFG;
      start    = 16'(`USB_DESC_HSCFG_ADDR);
    end else if (in_range(i_raddr, `USB_DESC_OSCFG_ADDR, `USB_DESC_OSCFG_LEN)) begin
      region_d = usb_desc_pkg::REG_OSCFG;
      start    = 16'(`USB_DESC_OSCFG_ADDR);
    end else if (in_range(i_raddr, `USB_DESC_STRLANG_ADDR, `USB_DESC_STRLANG_LEN)) begin
      region_d = usb_desc_pkg::REG_STRLANG;
      start    = 16'(`USB_DESC_STRLANG_ADDR);
    end else if (in_range(i_raddr, `USB_DESC_STRVENDOR_ADDR, `USB_DESC_STRVENDOR_LEN)) begin
      region_d = usb_desc_pkg::REG_STRVENDOR;
      start    = 16'(`USB_DESC_STRVENDOR_ADDR);
    end else if (in_range(i_raddr, `USB_DESC_STRPRODUCT_ADDR, `USB_DESC_STRPRODUCT_LEN)) begin
      region_d = usb_desc_pkg::REG_STRPRODUCT;
      start    = 16'(`USB_DESC_STRPRODUCT_ADDR);
    end else if (in_range(i_raddr, `USB_DESC_STRSERIAL_ADDR, `USB_DESC_STRSERIAL_LEN)) begin
      region_d = usb_desc_pkg::REG_STRSERIAL;
      start    = 16'(`USB_DESC_STRSERIAL_ADDR);
    end
  end

  assign diff = i_raddr - start;  // regions are <= 32 bytes, low byte is enough

  always_ff @(posedge CLK or posedge RESET) begin
    if (RESET) begin
      o_region <= usb_desc_pkg::REG_NONE;
      o_offset <= '0;
    end else begin
      o_region <= region_d;
      o_offset <= diff[7:0];
    end
  end

endmodule

/* src/usb_desc_pkg.sv */
package usb_desc_pkg;

  typedef logic [15:0] desc_addr_t;    // rom read address
  typedef logic [7:0]  desc_byte_t;    // one rom byte
  typedef logic [7:0]  desc_offset_t;  // byte index inside a region

  // which descriptor an address lands in
  typedef enum logic [3:0] {
    REG_NONE       = 4'd0,  // padding or past the end
    REG_DEV        = 4'd1,  // device descriptor
    REG_QUAL       = 4'd2,  // device qualifier
    REG_FSCFG      = 4'd3,  // full speed config
    REG_HSCFG      = 4'd4,  // high speed config
    REG_OSCFG      = 4'd5,  // other speed config
    REG_STRLANG    = 4'd6,  // string 0, language ids
    REG_STRVENDOR  = 4'd7,  // string 1
    REG_STRPRODUCT = 4'd8,  // string 2
    REG_STRSERIAL  = 4'd9   // string 3
  } desc_region_e;

endpackage

/* src/usb_desc_params.svh */
`ifndef USB_DESC_PARAMS_SVH
`define USB_DESC_PARAMS_SVH

// device identity
`define USB_VENDOR_ID        16'h33AA    // default idVendor
`define USB_PRODUCT_ID       16'h0000    // default idProduct
`define USB_VERSION_BCD      16'h0100    // bcdDevice, release 1.00

// power, 1 = self powered
`define USB_SELF_POWERED     1
`define USB_MAX_POWER        8'h32       // bMaxPower, 2 mA units -> 100 mA

// packet sizes
`define USB_EP0_MAXPKT       8'd64       // control pipe
`define USB_FS_MAXPKT        16'd64      // bulk at full speed
`define USB_HS_MAXPKT        16'd512     // bulk at high speed

// string contents, 32 chars max per string
`define USB_VENDOR_STR       "Video Camera"
`define USB_VENDOR_STR_LEN   12
`define USB_PRODUCT_STR      "Video Streamer"
`define USB_PRODUCT_STR_LEN  14
`define USB_SERIAL_STR       "12345678"
`define USB_SERIAL_STR_LEN   8

// rom layout, start addresses and lengths in bytes
`define USB_DESC_DEV_ADDR        0
`define USB_DESC_DEV_LEN         18
`define USB_DESC_QUAL_ADDR       20     // two pad bytes after device
`define USB_DESC_QUAL_LEN        10
`define USB_DESC_FSCFG_ADDR      32     // two pad bytes after qualifier
`define USB_DESC_FSCFG_LEN       32     // 9 + 9 + 7 + 7
`define USB_DESC_HSCFG_ADDR      (`USB_DESC_FSCFG_ADDR + `USB_DESC_FSCFG_LEN)
`define USB_DESC_HSCFG_LEN       32
`define USB_DESC_OSCFG_ADDR      (`USB_DESC_HSCFG_ADDR + `USB_DESC_HSCFG_LEN)
`define USB_DESC_OSCFG_LEN       32
`define USB_DESC_STRLANG_ADDR    (`USB_DESC_OSCFG_ADDR + `USB_DESC_OSCFG_LEN)
`define USB_DESC_STRLANG_LEN     4
`define USB_DESC_STRVENDOR_ADDR  (`USB_DESC_STRLANG_ADDR + `USB_DESC_STRLANG_LEN)
`define USB_DESC_STRVENDOR_LEN   (2 + 2 * `USB_VENDOR_STR_LEN)
`define USB_DESC_STRPRODUCT_ADDR (`USB_DESC_STRVENDOR_ADDR + `USB_DESC_STRVENDOR_LEN)
`define USB_DESC_STRPRODUCT_LEN  (2 + 2 * `USB_PRODUCT_STR_LEN)
`define USB_DESC_STRSERIAL_ADDR  (`USB_DESC_STRPRODUCT_ADDR + `USB_DESC_STRPRODUCT_LEN)
`define USB_DESC_STRSERIAL_LEN   (2 + 2 * `USB_SERIAL_STR_LEN)
`define USB_DESC_END_ADDR        (`USB_DESC_STRSERIAL_ADDR + `USB_DESC_STRSERIAL_LEN)

`endif
